// ==== dv/golden_vectors.txt ====
# op a1 a2 npop pop_top pop_next lva_read npush push_value nwrite wr_index wr_value offset
# hex fields; pops are served top first, the rest is what the DUT must produce
02 00 00 0 00000000 00000000 00000000 1 ffffffff 0 00 00000000 0001
08 00 00 0 00000000 00000000 00000000 1 00000005 0 00 00000000 0001
05 00 00 0 00000000 00000000 00000000 1 00000002 0 00 00000000 0001
10 85 3c 0 00000000 00000000 00000000 1 ffffff85 0 00 00000000 0002
11 80 01 0 00000000 00000000 00000000 1 ffff8001 0 00 00000000 0003
60 00 00 2 00000005 00000007 00000000 1 0000000c 0 00 00000000 0001
64 00 00 2 00000003 00000001 00000000 1 fffffffe 0 00 00000000 0001
68 00 00 2 fffffffd 00000007 00000000 1 ffffffeb 0 00 00000000 0001
7e 00 00 2 0f0f00ff 12345678 00000000 1 02040078 0 00 00000000 0001
80 00 00 2 f0000000 0000000f 00000000 1 f000000f 0 00 00000000 0001
82 00 00 2 ffff0000 12345678 00000000 1 edcb5678 0 00 00000000 0001
78 00 00 2 00000024 00000003 00000000 1 00000030 0 00 00000000 0001
7a 00 00 2 00000004 80000000 00000000 1 f8000000 0 00 00000000 0001
15 21 00 0 00000000 00000000 deadbeef 1 deadbeef 0 00 00000000 0002
1c 00 00 0 00000000 00000000 00000042 1 00000042 0 00 00000000 0001
36 17 00 1 cafef00d 00000000 00000000 0 00000000 1 17 cafef00d 0002
3e 00 00 1 00000099 00000000 00000000 0 00000000 1 03 00000099 0001
57 00 00 1 11111111 00000000 00000000 0 00000000 0 00 00000000 0001
59 00 00 1 0000abcd 00000000 00000000 2 0000abcd 0 00 00000000 0001
99 00 10 1 00000000 00000000 00000000 0 00000000 0 00 00000000 0010
9a 00 10 1 00000000 00000000 00000000 0 00000000 0 00 00000000 0003
9b ff f0 1 80000000 00000000 00000000 0 00000000 0 00 00000000 fff0
9c 00 08 1 ffffffff 00000000 00000000 0 00000000 0 00 00000000 0003
9d 00 20 1 00000001 00000000 00000000 0 00000000 0 00 00000000 0020
9e 00 0c 1 00000000 00000000 00000000 0 00000000 0 00 00000000 000c
9f 00 30 2 00000005 00000006 00000000 0 00000000 0 00 00000000 0003
a1 ff 00 2 00000001 ffffffff 00000000 0 00000000 0 00 00000000 ff00
a4 00 0a 2 00000002 00000002 00000000 0 00000000 0 00 00000000 000a
a7 fe 00 0 00000000 00000000 00000000 0 00000000 0 00 00000000 fe00
00 00 00 0 00000000 00000000 00000000 0 00000000 0 00 00000000 0001
ba 00 00 0 00000000 00000000 00000000 0 00000000 0 00 00000000 0001
84 01 05 0 00000000 00000000 00000000 0 00000000 0 00 00000000 0001

// ==== project.f ====
source/jvm_isa_pkg.sv
source/jvm_mem_pkg.sv
source/bc_decoder.sv
source/int_alu.sv
source/exec_sequencer.sv
source/jvm_control.sv
dv/tb_mem_models.sv
dv/tb_jvm_control.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the jvm_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_jvm_control -f project.f -o sim_tb_jvm_control
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_jvm_control)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== dv/tb_jvm_control.sv ====
`timescale 1ns/10ps

module tb_jvm_control;
    import jvm_isa_pkg::*;
    import jvm_mem_pkg::*;

    localparam int unsigned SEED = 32'hbb8e_6c8b;

    // one line of the golden file
    typedef struct packed {
        logic [7:0]  op;
        arg_bytes_t  args;
        logic [1:0]  n_pop;
        word_t       pop0;
        word_t       pop1;
        word_t       lva;
        logic [1:0]  n_push;
        word_t       push;
        logic [1:0]  n_wr;
        logic [7:0]  wr_index;
        word_t       wr_data;
        logic [15:0] offset;
    } vector_t;

    logic        clk;
    logic        rst;
    logic [7:0]  op_code;
    arg_bytes_t  args;
    logic [15:0] offset;
    logic        op_done;
    stack_req_t  stack_req;
    stack_rsp_t  stack_rsp;
    lva_req_t    lva_req;
    lva_rsp_t    lva_rsp;

    logic        clear;
    word_t       pop_data0;
    word_t       pop_data1;
    word_t       lva_data;
    int          pop_cnt;
    int          push_cnt;
    int          rd_cnt;
    int          wr_cnt;
    word_t       push_data0;
    word_t       push_data1;
    logic [7:0]  rd_index;
    logic [7:0]  wr_index;
    word_t       wr_data;

    vector_t     vectors[$];
    int          errors;
    int          checks;
    logic        loaded;

    jvm_control UUT (
        .clk       (clk),
        .rst       (rst),
        .op_code   (op_code),
        .args      (args),
        .offset    (offset),
        .op_done   (op_done),
        .stack_req (stack_req),
        .stack_rsp (stack_rsp),
        .lva_req   (lva_req),
        .lva_rsp   (lva_rsp)
    );

    tb_mem_models models (
        .clk        (clk),
        .clear      (clear),
        .stack_req  (stack_req),
        .stack_rsp  (stack_rsp),
        .lva_req    (lva_req),
        .lva_rsp    (lva_rsp),
        .pop_data0  (pop_data0),
        .pop_data1  (pop_data1),
        .lva_data   (lva_data),
        .pop_cnt    (pop_cnt),
        .push_cnt   (push_cnt),
        .push_data0 (push_data0),
        .push_data1 (push_data1),
        .rd_cnt     (rd_cnt),
        .rd_index   (rd_index),
        .wr_cnt     (wr_cnt),
        .wr_index   (wr_index),
        .wr_data    (wr_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_offset(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_index(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [0:12];
        vector_t     v;
        fd = $fopen("dv/golden_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file dv/golden_vectors.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;  // blank line or column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
            if (n != 13) begin
                $display("golden file line has %0d fields instead of 13: %s", n, line);
                errors++;
            end else begin
                v.op       = f[0][7:0];
                v.args     = {f[1][7:0], f[2][7:0]};
                v.n_pop    = f[3][1:0];
                v.pop0     = f[4];
                v.pop1     = f[5];
                v.lva      = f[6];
                v.n_push   = f[7][1:0];
                v.push     = f[8];
                v.n_wr     = f[9][1:0];
                v.wr_index = f[10][7:0];
                v.wr_data  = f[11];
                v.offset   = f[12][15:0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // apply one instruction, wait for op_done, compare the port traffic
    task automatic run_vector(input vector_t v);
        int         cycles;
        int         exp_reads;
        logic [7:0] exp_rd_index;
        op_code   = v.op;
        args      = v.args;
        pop_data0 = v.pop0;
        pop_data1 = v.pop1;
        lva_data  = v.lva;
        clear     = 1'b1;
        cycles    = 0;
        // only the load forms read the local array
        exp_reads    = 0;
        exp_rd_index = '0;
        if (v.op == ILOAD) begin
            exp_reads    = 1;
            exp_rd_index = v.args.lit.arg1;
        end else if (v.op >= ILOAD_0 && v.op <= ILOAD_3) begin
            exp_reads    = 1;
            exp_rd_index = v.op - ILOAD_0;
        end
        do begin
            @(posedge clk);
            #5;
            clear = 1'b0;
            cycles++;
        end while (op_done !== 1'b1);
        if (cycles <= FETCH_WAIT) begin
            $display("op_done for opcode %h came after %0d cycles, inside the fetch wait",
                     v.op, cycles);
            errors++;
        end
        check_offset("offset", offset, v.offset);
        check_count("pops", pop_cnt, int'(v.n_pop));
        check_count("pushes", push_cnt, int'(v.n_push));
        check_count("local reads", rd_cnt, exp_reads);
        check_count("local writes", wr_cnt, int'(v.n_wr));
        if (v.n_push != 2'd0)
            check_word("push value", push_data0, v.push);
        if (v.n_push == 2'd2)
            check_word("second push value", push_data1, v.push);  // dup
        if (exp_reads != 0)
            check_index("read index", rd_index, exp_rd_index);
        if (v.n_wr != 2'd0) begin
            check_index("write index", wr_index, v.wr_index);
            check_word("write value", wr_data, v.wr_data);
        end
    endtask

    // watchdog sized from the number of vectors
    initial begin
        wait (loaded === 1'b1);
        repeat (vectors.size() * 40 + 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles",
                 vectors.size() * 40 + 100);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        op_code   = NOP;
        args      = '0;
        clear     = 1'b0;
        pop_data0 = '0;
        pop_data1 = '0;
        lva_data  = '0;
        errors    = 0;
        checks    = 0;
        loaded    = 1'b0;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no vectors were read from the golden file");
            errors++;
        end
        loaded = 1'b1;

        repeat (8) begin
            @(posedge clk);
            #5;
            check_flag("op_done in reset", op_done, 1'b0);
        end
        check_offset("offset after reset", offset, 16'h0000);
        check_flag("stack trigger after reset", stack_req.trigger, 1'b0);
        check_flag("lva trigger after reset", lva_req.trigger, 1'b0);
        rst = 1'b0;

        foreach (vectors[i])
            run_vector(vectors[i]);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== dv/tb_mem_models.sv ====
`timescale 1ns/10ps

module tb_mem_models (
    input  logic                    clk,
    input  logic                    clear,       // start of a new instruction
    input  jvm_mem_pkg::stack_req_t stack_req,
    output jvm_mem_pkg::stack_rsp_t stack_rsp,
    input  jvm_mem_pkg::lva_req_t   lva_req,
    output jvm_mem_pkg::lva_rsp_t   lva_rsp,
    input  jvm_mem_pkg::word_t      pop_data0,   // top of stack
    input  jvm_mem_pkg::word_t      pop_data1,
    input  jvm_mem_pkg::word_t      lva_data,
    output int                      pop_cnt,
    output int                      push_cnt,
    output jvm_mem_pkg::word_t      push_data0,
    output jvm_mem_pkg::word_t      push_data1,
    output int                      rd_cnt,
    output logic [7:0]              rd_index,
    output int                      wr_cnt,
    output logic [7:0]              wr_index,
    output jvm_mem_pkg::word_t      wr_data
);
    import jvm_mem_pkg::*;

    int stack_wait;  // cycles left until stack done
    int lva_wait;

    initial begin
        stack_rsp  = '0;
        lva_rsp    = '0;
        stack_wait = 0;
        lva_wait   = 0;
        pop_cnt    = 0;
        push_cnt   = 0;
        rd_cnt     = 0;
        wr_cnt     = 0;
        push_data0 = '0;
        push_data1 = '0;
        rd_index   = '0;
        wr_index   = '0;
        wr_data    = '0;
        forever begin
            @(posedge clk);
            #2;
            stack_rsp.done = 1'b0;  // done is a one cycle pulse
            lva_rsp.done   = 1'b0;
            if (clear) begin
                pop_cnt  = 0;
                push_cnt = 0;
                rd_cnt   = 0;
                wr_cnt   = 0;
            end

            // evaluation stack
            if (stack_req.trigger) begin
                stack_wait = int'($urandom % 32'd4) + 1;
                if (stack_req.push) begin
                    if (push_cnt == 0)
                        push_data0 = stack_req.wdata;
                    else
                        push_data1 = stack_req.wdata;
                    push_cnt++;
                end else begin
                    stack_rsp.rdata = (pop_cnt == 0) ? pop_data0 : pop_data1;
                    pop_cnt++;
                end
            end else if (stack_wait != 0) begin
                stack_wait--;
                if (stack_wait == 0)
                    stack_rsp.done = 1'b1;
            end

            // local variable array
            if (lva_req.trigger) begin
                lva_wait = int'($urandom % 32'd4) + 1;
                if (lva_req.write) begin
                    wr_index = lva_req.index;
                    wr_data  = lva_req.wdata;
                    wr_cnt++;
                end else begin
                    rd_index      = lva_req.index;
                    lva_rsp.rdata = lva_data;
                    rd_cnt++;
                end
            end else if (lva_wait != 0) begin
                lva_wait--;
                if (lva_wait == 0)
                    lva_rsp.done = 1'b1;
            end
        end
    end

endmodule

// ==== source/jvm_control.sv ====
`timescale 1ns/10ps

module jvm_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [7:0]              op_code,
    input  jvm_isa_pkg::arg_bytes_t args,
    output logic [15:0]             offset,
    output logic                    op_done,
    output jvm_mem_pkg::stack_req_t stack_req,
    input  jvm_mem_pkg::stack_rsp_t stack_rsp,
    output jvm_mem_pkg::lva_req_t   lva_req,
    input  jvm_mem_pkg::lva_rsp_t   lva_rsp
);
    import jvm_isa_pkg::*;
    import jvm_mem_pkg::*;

    decoded_t dec;
    word_t    a;           // second pop, left operand
    word_t    b;           // first pop, or zero for ifXX
    word_t    alu_result;
    logic     taken;

    bc_decoder u_decoder (
        .op_code (op_code),
        .dec     (dec)
    );

    int_alu u_alu (
        .a      (a),
        .b      (b),
        .alu_op (dec.alu_op),
        .cmp    (dec.cmp),
        .result (alu_result),
        .taken  (taken)
    );

    exec_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .args       (args),
        .alu_result (alu_result),
        .taken      (taken),
        .a          (a),
        .b          (b),
        .offset     (offset),
        .op_done    (op_done),
        .stack_req  (stack_req),
        .stack_rsp  (stack_rsp),
        .lva_req    (lva_req),
        .lva_rsp    (lva_rsp)
    );

endmodule

// ==== source/exec_sequencer.sv ====
`timescale 1ns/10ps

module exec_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  jvm_isa_pkg::decoded_t   dec,
    input  jvm_isa_pkg::arg_bytes_t args,
    input  jvm_mem_pkg::word_t      alu_result,
    input  logic                    taken,
    output jvm_mem_pkg::word_t      a,
    output jvm_mem_pkg::word_t      b,
    output logic [15:0]             offset,
    output logic                    op_done,
    output jvm_mem_pkg::stack_req_t stack_req,
    input  jvm_mem_pkg::stack_rsp_t stack_rsp,
    output jvm_mem_pkg::lva_req_t   lva_req,
    input  jvm_mem_pkg::lva_rsp_t   lva_rsp
);
    import jvm_isa_pkg::*;
    import jvm_mem_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_POP, ST_POP_WAIT, ST_LVA, ST_LVA_WAIT, ST_EXEC, ST_PUSH, ST_PUSH_WAIT
    } state_e;

    state_e      state;
    logic [1:0]  wait_cnt;   // fetch delay countdown
    logic [1:0]  pops_left;
    logic [1:0]  push_cnt;
    word_t       push_word;
    logic [15:0] next_offset;

    // value for the stack push, selected by class
    always_comb begin
        case (dec.cls)
            CLS_CONST:   push_word = (dec.constval == 3'd7) ? '1 : {29'd0, dec.constval};
            CLS_LITERAL: begin
                if (dec.argc == 2'd1)  // bipush
                    push_word = {{24{args.lit.arg1[7]}}, args.lit.arg1};
                else
                    push_word = {{16{args.branch_offset[15]}}, args.branch_offset};
            end
            CLS_ALU:     push_word = alu_result;
            default:     push_word = a;  // local read or dup source
        endcase
    end

    always_comb begin
        if (dec.cls == CLS_BRANCH && (dec.is_goto || taken))
            next_offset = args.branch_offset;
        else
            next_offset = 16'(dec.argc) + 16'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            wait_cnt          <= 2'(FETCH_WAIT);
            op_done           <= 1'b0;
            offset            <= '0;
            pops_left         <= '0;
            push_cnt          <= '0;
            stack_req.trigger <= 1'b0;
            lva_req.trigger   <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wait_cnt != 2'd0) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end else if (dec.cls == CLS_NONE) begin
                        op_done  <= 1'b1;           // nop and unknown opcodes
                        offset   <= next_offset;
                        wait_cnt <= 2'(FETCH_WAIT);
                    end else begin
                        pops_left <= dec.pops;
                        if (dec.cls == CLS_BRANCH && !dec.cmp_two)
                            b <= '0;                // compare against zero
                        if (dec.pops != 2'd0)
                            state <= ST_POP;
                        else if (dec.cls == CLS_LOAD)
                            state <= ST_LVA;
                        else
                            state <= ST_EXEC;
                    end
                end
                ST_POP: begin
                    stack_req.push    <= 1'b0;
                    stack_req.trigger <= 1'b1;
                    state             <= ST_POP_WAIT;
                end
                ST_POP_WAIT: begin
                    stack_req.trigger <= 1'b0;
                    if (stack_rsp.done) begin
                        // first of two pops is the right operand
                        if (pops_left == 2'd2)
                            b <= stack_rsp.rdata;
                        else
                            a <= stack_rsp.rdata;
                        pops_left <= pops_left - 2'd1;
                        if (pops_left != 2'd1)
                            state <= ST_POP;
                        else if (dec.cls == CLS_STORE)
                            state <= ST_LVA;
                        else
                            state <= ST_EXEC;
                    end
                end
                ST_LVA: begin
                    lva_req.write   <= (dec.cls == CLS_STORE);
                    lva_req.index   <= (dec.argc == 2'd1) ? args.lit.arg1
                                                          : {6'd0, dec.lva_short_index};
                    lva_req.wdata   <= a;
                    lva_req.trigger <= 1'b1;
                    state           <= ST_LVA_WAIT;
                end
                ST_LVA_WAIT: begin
                    lva_req.trigger <= 1'b0;
                    if (lva_rsp.done) begin
                        if (!lva_req.write)
                            a <= lva_rsp.rdata;  // pushed in exec
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    stack_req.wdata <= push_word;
                    push_cnt        <= dec.pushes;
                    if (dec.pushes != 2'd0) begin
                        state <= ST_PUSH;
                    end else begin
                        op_done  <= 1'b1;
                        offset   <= next_offset;
                        wait_cnt <= 2'(FETCH_WAIT);
                        state    <= ST_IDLE;
                    end
                end
                ST_PUSH: begin
                    stack_req.push    <= 1'b1;
                    stack_req.trigger <= 1'b1;
                    state             <= ST_PUSH_WAIT;
                end
                ST_PUSH_WAIT: begin
                    stack_req.trigger <= 1'b0;
                    if (stack_rsp.done) begin
                        push_cnt <= push_cnt - 2'd1;
                        if (push_cnt != 2'd1) begin
                            state <= ST_PUSH;  // second push of dup
                        end else begin
                            op_done  <= 1'b1;
                            offset   <= next_offset;
                            wait_cnt <= 2'(FETCH_WAIT);
                            state    <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/int_alu.sv ====
`timescale 1ns/10ps

module int_alu (
    input  jvm_mem_pkg::word_t   a,
    input  jvm_mem_pkg::word_t   b,
    input  jvm_isa_pkg::alu_op_e alu_op,
    input  jvm_isa_pkg::cmp_e    cmp,
    output jvm_mem_pkg::word_t   result,
    output logic                 taken
);
    import jvm_isa_pkg::*;

    logic signed [31:0] sa;
    logic signed [31:0] sb;

    assign sa = a;
    assign sb = b;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_MUL: result = a * b;         // low 32 bits only
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SHL: result = a << b[4:0];
            ALU_SHR: result = sa >>> b[4:0]; // arithmetic shift
            default: result = a;
        endcase
    end

    // branch condition, second pop compared against first pop (or zero)
    always_comb begin
        case (cmp)
            CMP_EQ:  taken = (sa == sb);
            CMP_NE:  taken = (sa != sb);
            CMP_LT:  taken = (sa < sb);
            CMP_GE:  taken = (sa >= sb);
            CMP_GT:  taken = (sa > sb);
            CMP_LE:  taken = (sa <= sb);
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== source/bc_decoder.sv ====
`timescale 1ns/10ps

module bc_decoder (
    input  logic [7:0]            op_code,
    output jvm_isa_pkg::decoded_t dec
);
    import jvm_isa_pkg::*;

    always_comb begin
        dec        = '0;
        dec.cls    = CLS_NONE;  // unknown opcodes fall through as NONE
        dec.alu_op = ALU_ADD;
        dec.cmp    = CMP_EQ;

        case (op_code) inside
            [ICONST_M1:ICONST_5]: begin
                dec.cls      = CLS_CONST;
                dec.constval = 3'(op_code - ICONST_0);  // iconst_m1 wraps to 7
                dec.pushes   = 2'd1;
            end
            BIPUSH, SIPUSH: begin
                dec.cls    = CLS_LITERAL;
                dec.argc   = (op_code == SIPUSH) ? 2'd2 : 2'd1;
                dec.pushes = 2'd1;
            end
            ILOAD: begin
                dec.cls    = CLS_LOAD;
                dec.argc   = 2'd1;
                dec.pushes = 2'd1;
            end
            [ILOAD_0:ILOAD_3]: begin
                dec.cls             = CLS_LOAD;
                dec.lva_short_index = 2'(op_code - ILOAD_0);
                dec.pushes          = 2'd1;
            end
            ISTORE: begin
                dec.cls  = CLS_STORE;
                dec.argc = 2'd1;
                dec.pops = 2'd1;
            end
            [ISTORE_0:ISTORE_3]: begin
                dec.cls             = CLS_STORE;
                dec.lva_short_index = 2'(op_code - ISTORE_0);
                dec.pops            = 2'd1;
            end
            POP, DUP: begin
                dec.cls    = CLS_STACKOP;
                dec.pops   = 2'd1;
                dec.pushes = (op_code == DUP) ? 2'd2 : 2'd0;  // dup pushes the value back twice
            end
            IADD, ISUB, IMUL, IAND, IOR, IXOR, ISHL, ISHR: begin
                dec.cls    = CLS_ALU;
                dec.pops   = 2'd2;
                dec.pushes = 2'd1;
                case (op_code)
                    ISUB:    dec.alu_op = ALU_SUB;
                    IMUL:    dec.alu_op = ALU_MUL;
                    IAND:    dec.alu_op = ALU_AND;
                    IOR:     dec.alu_op = ALU_OR;
                    IXOR:    dec.alu_op = ALU_XOR;
                    ISHL:    dec.alu_op = ALU_SHL;
                    ISHR:    dec.alu_op = ALU_SHR;
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            [IFEQ:IFLE]: begin
                dec.cls  = CLS_BRANCH;
                dec.argc = 2'd2;
                dec.pops = 2'd1;
                dec.cmp  = cmp_e'(3'(op_code - IFEQ));
            end
            [IF_ICMPEQ:IF_ICMPLE]: begin
                dec.cls     = CLS_BRANCH;
                dec.argc    = 2'd2;
                dec.pops    = 2'd2;
                dec.cmp     = cmp_e'(3'(op_code - IF_ICMPEQ));
                dec.cmp_two = 1'b1;
            end
            GOTO: begin
                dec.cls     = CLS_BRANCH;
                dec.argc    = 2'd2;
                dec.is_goto = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/jvm_mem_pkg.sv ====
package jvm_mem_pkg;

    typedef logic [31:0] word_t;

    // evaluation stack port
    typedef struct packed {
        logic  push;     // high to push, low to pop
        logic  trigger;  // one cycle start pulse
        word_t wdata;
    } stack_req_t;

    typedef struct packed {
        logic  done;     // rdata valid in this cycle
        word_t rdata;
    } stack_rsp_t;

    // local variable array port
    typedef struct packed {
        logic       write;    // high to write, low to read
        logic       trigger;
        logic [7:0] index;
        word_t      wdata;
    } lva_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } lva_rsp_t;

endpackage

// ==== source/jvm_isa_pkg.sv ====
package jvm_isa_pkg;

    // opcodes handled by the control unit (JVM encodings)
    localparam logic [7:0] NOP       = 8'h00;
    localparam logic [7:0] ICONST_M1 = 8'h02;
    localparam logic [7:0] ICONST_0  = 8'h03;
    localparam logic [7:0] ICONST_5  = 8'h08;
    localparam logic [7:0] BIPUSH    = 8'h10;
    localparam logic [7:0] SIPUSH    = 8'h11;
    localparam logic [7:0] ILOAD     = 8'h15;
    localparam logic [7:0] ILOAD_0   = 8'h1a;
    localparam logic [7:0] ILOAD_3   = 8'h1d;
    localparam logic [7:0] ISTORE    = 8'h36;
    localparam logic [7:0] ISTORE_0  = 8'h3b;
    localparam logic [7:0] ISTORE_3  = 8'h3e;
    localparam logic [7:0] POP       = 8'h57;
    localparam logic [7:0] DUP       = 8'h59;
    localparam logic [7:0] IADD      = 8'h60;
    localparam logic [7:0] ISUB      = 8'h64;
    localparam logic [7:0] IMUL      = 8'h68;
    localparam logic [7:0] ISHL      = 8'h78;
    localparam logic [7:0] ISHR      = 8'h7a;
    localparam logic [7:0] IAND      = 8'h7e;
    localparam logic [7:0] IOR       = 8'h80;
    localparam logic [7:0] IXOR      = 8'h82;
    localparam logic [7:0] IFEQ      = 8'h99;
    localparam logic [7:0] IFLE      = 8'h9e;
    localparam logic [7:0] IF_ICMPEQ = 8'h9f;
    localparam logic [7:0] IF_ICMPLE = 8'ha4;
    localparam logic [7:0] GOTO      = 8'ha7;

    // idle cycles after op_done while the next opcode is fetched
    localparam int unsigned FETCH_WAIT = 3;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR
    } alu_op_e;

    // same order as the ifXX / if_icmpXX opcodes
    typedef enum logic [2:0] {
        CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_GT, CMP_LE
    } cmp_e;

    typedef struct packed {
        logic [7:0] arg1;  // hi byte, pc + 1
        logic [7:0] arg2;  // lo byte, pc + 2
    } arg_pair_t;

    typedef union packed {
        logic signed [15:0] branch_offset;
        arg_pair_t          lit;
    } arg_bytes_t;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_CONST, CLS_LITERAL, CLS_LOAD,
        CLS_STORE, CLS_ALU, CLS_STACKOP, CLS_BRANCH
    } op_class_e;

    typedef struct packed {
        op_class_e  cls;
        alu_op_e    alu_op;
        cmp_e       cmp;
        logic       cmp_two;          // compare against a second operand, not zero
        logic [2:0] constval;         // 7 encodes -1
        logic [1:0] lva_short_index;
        logic [1:0] argc;
        logic [1:0] pops;
        logic [1:0] pushes;
        logic       is_goto;
    } decoded_t;

endpackage
